// ==== rvPkg.sv ====
`default_nettype none

package rvPkg;

    // opcodes of the supported RV32I subset
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASSB   // passB for lui
    } aluFnT;

    typedef enum logic [1:0] {B_REG, B_IMM, B_SHAMT} bSelT;   // operand b source

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pcSelT;

    // field layouts, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFieldsT;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFieldsT;

    typedef struct packed {
        logic       imm12;      // sign bit
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFieldsT;

    typedef struct packed {
        logic       imm20;      // sign bit
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFieldsT;

    // one instruction word, four readings
    typedef union packed {
        rFieldsT r;
        iFieldsT i;
        bFieldsT b;
        jFieldsT j;
    } instrU;

endpackage

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        nrst,
    input  logic        we,
    input  logic [4:0]  writeAddr,
    input  logic [4:0]  sourceA,
    input  logic [4:0]  sourceB,
    input  logic [31:0] result,     // write data from commit
    output logic [31:0] opA,
    output logic [31:0] opB
);

    logic [31:0] mem [1:31];        // x0 is not stored
    logic        doWrite;

    assign doWrite = we && writeAddr != 5'd0;

    // read value seen at this edge, with write-through
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0)
            return 32'd0;
        else if (doWrite && writeAddr == addr)
            return result;
        else
            return mem[addr];
    endfunction

    always_ff @(posedge clk)
    begin
        if (doWrite)
            mem[writeAddr] <= result;
    end

    // synchronous read ports
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            opA <= '0;
            opB <= '0;
        end
        else
        begin
            opA <= readPort(sourceA);
            opB <= readPort(sourceB);
        end
    end

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic          clk,
    input  logic          nrst,
    input  logic          instrValid,   // low cycle becomes a bubble
    input  rvPkg::instrU  instr,
    input  logic [31:0]   pc,
    output logic [4:0]    rs1,          // to regFile read ports
    output logic [4:0]    rs2,
    output logic [4:0]    rd3,
    output logic [4:0]    shamt,
    output logic          we3,
    output rvPkg::aluFnT  aluFn3,
    output rvPkg::bSelT   bSel3,
    output logic [2:0]    fn3,          // funct3 for branch compare
    output rvPkg::pcSelT  pcSel3,
    output logic [31:0]   pc3,
    output logic [31:0]   iImm3,
    output logic [31:0]   bImm3,
    output logic [31:0]   jImm3
);

    rvPkg::instrU  instrQ;      // word held so the regfile reads at the next edge
    logic          weNext;
    rvPkg::aluFnT  aluFnNext;
    rvPkg::bSelT   bSelNext;
    rvPkg::pcSelT  pcSelNext;
    logic [31:0]   iImmNext;
    logic [31:0]   jImmNext;
    logic [31:0]   bImmNext;
    logic [31:0]   uImm;

    // funct3 to alu op, alt picks sub / sra
    function automatic rvPkg::aluFnT aluOf(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
            3'b001:  return rvPkg::ALU_SLL;
            3'b010:  return rvPkg::ALU_SLT;
            3'b011:  return rvPkg::ALU_SLTU;
            3'b100:  return rvPkg::ALU_XOR;
            3'b101:  return alt ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
            3'b110:  return rvPkg::ALU_OR;
            default: return rvPkg::ALU_AND;
        endcase
    endfunction

    assign uImm     = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'd0};
    assign bImmNext = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10to5, instr.b.imm4to1, 1'b0};

    always_comb
    begin
        weNext    = 1'b0;               // bubble unless decoded below
        aluFnNext = rvPkg::ALU_ADD;
        bSelNext  = rvPkg::B_REG;
        pcSelNext = rvPkg::PC_SEQ;
        iImmNext  = {{20{instr.i.imm12[11]}}, instr.i.imm12};
        jImmNext  = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                     instr.j.imm11, instr.j.imm10to1, 1'b0};
        if (instrValid)
        begin
            case (instr.r.opcode)
                rvPkg::OP_OP:
                begin
                    weNext    = 1'b1;
                    aluFnNext = aluOf(instr.r.funct3, instr.r.funct7[5]);
                end
                rvPkg::OP_IMM:
                begin
                    weNext    = 1'b1;
                    // only srai uses the alt bit, addi has no sub form
                    aluFnNext = aluOf(instr.r.funct3,
                                      instr.r.funct3 == 3'b101 && instr.r.funct7[5]);
                    bSelNext  = (instr.r.funct3[1:0] == 2'b01) ? rvPkg::B_SHAMT : rvPkg::B_IMM;
                end
                rvPkg::OP_LUI:
                begin
                    weNext    = 1'b1;
                    aluFnNext = rvPkg::ALU_PASSB;
                    bSelNext  = rvPkg::B_IMM;
                    iImmNext  = uImm;           // reaches opB through the imm path
                    jImmNext  = uImm;
                end
                rvPkg::OP_JAL:
                begin
                    weNext    = 1'b1;
                    pcSelNext = rvPkg::PC_JAL;
                end
                rvPkg::OP_JALR:
                begin
                    weNext    = 1'b1;
                    bSelNext  = rvPkg::B_IMM;   // target is rs1 + imm
                    pcSelNext = rvPkg::PC_JALR;
                end
                rvPkg::OP_BRANCH: pcSelNext = rvPkg::PC_BRANCH;
                default:          weNext    = 1'b0;   // unsupported opcode acts as bubble
            endcase
            if (instr.r.rd == 5'd0)
                weNext = 1'b0;                      // x0 never written
        end
    end

    // pipe #3
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            instrQ <= '0;
            rd3    <= '0;
            we3    <= 1'b0;
            aluFn3 <= rvPkg::ALU_ADD;
            bSel3  <= rvPkg::B_REG;
            fn3    <= '0;
            pcSel3 <= rvPkg::PC_SEQ;
            pc3    <= '0;
            iImm3  <= '0;
            bImm3  <= '0;
            jImm3  <= '0;
        end
        else
        begin
            instrQ <= instr;
            rd3    <= weNext ? instr.r.rd : 5'd0;   // non-writers retire with rd 0
            we3    <= weNext;
            aluFn3 <= aluFnNext;
            bSel3  <= bSelNext;
            fn3    <= instr.r.funct3;
            pcSel3 <= pcSelNext;
            pc3    <= pc;
            iImm3  <= iImmNext;
            bImm3  <= bImmNext;
            jImm3  <= jImmNext;
        end
    end

    assign rs1   = instrQ.r.rs1;
    assign rs2   = instrQ.r.rs2;
    assign shamt = instrQ.r.rs2;    // same bits as rs2 in the shift-imm layout

endmodule

`default_nettype wire

// ==== issueStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issueStage (
    input  logic          clk,
    input  logic          nrst,
    input  logic          we6,          // write port from commit
    input  logic [4:0]    rdAddr6,
    input  logic [31:0]   wb6,
    input  logic [4:0]    rs1,
    input  logic [4:0]    rs2,
    input  logic [4:0]    rd3,
    input  logic [4:0]    shamt,
    input  logic          we3,
    input  rvPkg::aluFnT  aluFn3,
    input  rvPkg::bSelT   bSel3,
    input  logic [2:0]    fn3,
    input  rvPkg::pcSelT  pcSel3,
    input  logic [31:0]   pc3,
    input  logic [31:0]   iImm3,
    input  logic [31:0]   bImm3,
    input  logic [31:0]   jImm3,
    output logic [31:0]   opA,
    output logic [31:0]   opB,
    output logic [4:0]    rd4,
    output logic          we4,
    output rvPkg::aluFnT  aluFn4,
    output logic [2:0]    fn4,
    output rvPkg::pcSelT  pcSel4,
    output logic [31:0]   pc4,
    output logic [31:0]   bImm4,
    output logic [31:0]   jImm4
);

    rvPkg::bSelT  bSel4;
    logic [4:0]   shamt4;
    logic [31:0]  iImm4;
    logic [31:0]  regB;             // second regfile port, before the mux

    // pipe #4, lines up with the regfile read edge
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            rd4    <= '0;
            we4    <= 1'b0;
            aluFn4 <= rvPkg::ALU_ADD;
            bSel4  <= rvPkg::B_REG;
            fn4    <= '0;
            pcSel4 <= rvPkg::PC_SEQ;
            pc4    <= '0;
            shamt4 <= '0;
            iImm4  <= '0;
            bImm4  <= '0;
            jImm4  <= '0;
        end
        else
        begin
            rd4    <= rd3;
            we4    <= we3;
            aluFn4 <= aluFn3;
            bSel4  <= bSel3;
            fn4    <= fn3;
            pcSel4 <= pcSel3;
            pc4    <= pc3;
            shamt4 <= shamt;
            iImm4  <= iImm3;
            bImm4  <= bImm3;
            jImm4  <= jImm3;
        end
    end

    regFile i_regFile (
        .clk(clk), .nrst(nrst), .we(we6), .writeAddr(rdAddr6),
        .sourceA(rs1), .sourceB(rs2), .result(wb6),
        .opA(opA), .opB(regB)
    );

    // operand b select
    always_comb
    begin
        case (bSel4)
            rvPkg::B_IMM:   opB = iImm4;            // also carries lui's upper imm
            rvPkg::B_SHAMT: opB = {27'd0, shamt4};
            default:        opB = regB;
        endcase
    end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic          clk,
    input  logic          nrst,
    input  logic [31:0]   opA,
    input  logic [31:0]   opB,
    input  logic [4:0]    rd4,
    input  logic          we4,
    input  rvPkg::aluFnT  aluFn4,
    input  logic [2:0]    fn4,          // branch condition
    input  rvPkg::pcSelT  pcSel4,
    input  logic [31:0]   pc4,
    input  logic [31:0]   bImm4,
    input  logic [31:0]   jImm4,
    output logic          branchTaken,
    output logic [31:0]   branchTarget,
    output logic [31:0]   aluRes5,
    output logic [31:0]   link5,
    output logic [4:0]    rd5,
    output logic          we5,
    output rvPkg::pcSelT  pcSel5
);

    logic [31:0] aluRes;
    logic [31:0] link;
    logic [31:0] jalrSum;
    logic        condTrue;

    // alu
    always_comb
    begin
        case (aluFn4)
            rvPkg::ALU_SUB:   aluRes = opA - opB;
            rvPkg::ALU_AND:   aluRes = opA & opB;
            rvPkg::ALU_OR:    aluRes = opA | opB;
            rvPkg::ALU_XOR:   aluRes = opA ^ opB;
            rvPkg::ALU_SLL:   aluRes = opA << opB[4:0];
            rvPkg::ALU_SRL:   aluRes = opA >> opB[4:0];
            rvPkg::ALU_SRA:   aluRes = $signed(opA) >>> opB[4:0];
            rvPkg::ALU_SLT:   aluRes = {31'd0, $signed(opA) < $signed(opB)};
            rvPkg::ALU_SLTU:  aluRes = {31'd0, opA < opB};
            rvPkg::ALU_PASSB: aluRes = opB;                 // lui
            default:          aluRes = opA + opB;
        endcase
    end

    // branch compare by funct3
    always_comb
    begin
        case (fn4)
            3'b000:  condTrue = opA == opB;                     // beq
            3'b001:  condTrue = opA != opB;                     // bne
            3'b100:  condTrue = $signed(opA) < $signed(opB);    // blt
            3'b101:  condTrue = $signed(opA) >= $signed(opB);   // bge
            3'b110:  condTrue = opA < opB;                      // bltu
            3'b111:  condTrue = opA >= opB;                     // bgeu
            default: condTrue = 1'b0;
        endcase
    end

    assign link    = pc4 + 32'd4;
    assign jalrSum = opA + opB;

    // outcome is reported only, nothing is redirected
    always_comb
    begin
        branchTaken  = 1'b0;
        branchTarget = link;
        case (pcSel4)
            rvPkg::PC_BRANCH:
            begin
                branchTaken  = condTrue;
                branchTarget = pc4 + bImm4;
            end
            rvPkg::PC_JAL:
            begin
                branchTaken  = 1'b1;
                branchTarget = pc4 + jImm4;
            end
            rvPkg::PC_JALR:
            begin
                branchTaken  = 1'b1;
                branchTarget = {jalrSum[31:1], 1'b0};   // lsb cleared per spec
            end
            default: branchTaken = 1'b0;
        endcase
    end

    // pipe #5
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            aluRes5 <= '0;
            link5   <= '0;
            rd5     <= '0;
            we5     <= 1'b0;
            pcSel5  <= rvPkg::PC_SEQ;
        end
        else
        begin
            aluRes5 <= aluRes;
            link5   <= link;
            rd5     <= rd4;
            we5     <= we4;
            pcSel5  <= pcSel4;
        end
    end

endmodule

`default_nettype wire

// ==== commitStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module commitStage (
    input  logic          clk,
    input  logic          nrst,
    input  logic [31:0]   aluRes5,
    input  logic [31:0]   link5,        // pc + 4
    input  logic [4:0]    rd5,
    input  logic          we5,
    input  rvPkg::pcSelT  pcSel5,
    output logic          we6,
    output logic [4:0]    rdAddr6,
    output logic [31:0]   wb6,
    output logic          retireValid,
    output logic [4:0]    retireRd,
    output logic [31:0]   retireData
);

    logic        isJump;
    logic        valid6;
    logic [31:0] wbNext;

    assign isJump = pcSel5 == rvPkg::PC_JAL || pcSel5 == rvPkg::PC_JALR;
    assign wbNext = isJump ? link5 : aluRes5;   // jumps write the link

    // pipe #6
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            we6     <= 1'b0;
            rdAddr6 <= '0;
            wb6     <= '0;
            valid6  <= 1'b0;
        end
        else
        begin
            we6     <= we5;
            rdAddr6 <= rd5;
            wb6     <= wbNext;
            valid6  <= we5 || pcSel5 != rvPkg::PC_SEQ;  // branches retire without a write
        end
    end

    assign retireValid = valid6;
    assign retireRd    = rdAddr6;
    assign retireData  = wb6;

endmodule

`default_nettype wire

// ==== pipeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeTop (
    input  logic          clk,
    input  logic          nrst,
    input  logic          instrValid,
    input  rvPkg::instrU  instr,
    input  logic [31:0]   pc,
    output logic          branchTaken,
    output logic [31:0]   branchTarget,
    output logic          retireValid,
    output logic [4:0]    retireRd,
    output logic [31:0]   retireData
);

    // pipe #3
    logic [4:0]    rs1, rs2, rd3, shamt;
    logic          we3;
    rvPkg::aluFnT  aluFn3;
    rvPkg::bSelT   bSel3;
    logic [2:0]    fn3;
    rvPkg::pcSelT  pcSel3;
    logic [31:0]   pc3, iImm3, bImm3, jImm3;
    // pipe #4
    logic [31:0]   opA, opB, pc4, bImm4, jImm4;
    logic [4:0]    rd4;
    logic          we4;
    rvPkg::aluFnT  aluFn4;
    logic [2:0]    fn4;
    rvPkg::pcSelT  pcSel4;
    // pipe #5 and the write-back loop
    logic [31:0]   aluRes5, link5, wb6;
    logic [4:0]    rd5, rdAddr6;
    logic          we5, we6;
    rvPkg::pcSelT  pcSel5;

    decodeStage i_decode (
        .clk(clk), .nrst(nrst), .instrValid(instrValid), .instr(instr), .pc(pc),
        .rs1(rs1), .rs2(rs2), .rd3(rd3), .shamt(shamt), .we3(we3), .aluFn3(aluFn3),
        .bSel3(bSel3), .fn3(fn3), .pcSel3(pcSel3), .pc3(pc3), .iImm3(iImm3),
        .bImm3(bImm3), .jImm3(jImm3)
    );

    issueStage i_issue (
        .clk(clk), .nrst(nrst), .we6(we6), .rdAddr6(rdAddr6), .wb6(wb6),
        .rs1(rs1), .rs2(rs2), .rd3(rd3), .shamt(shamt), .we3(we3), .aluFn3(aluFn3),
        .bSel3(bSel3), .fn3(fn3), .pcSel3(pcSel3), .pc3(pc3), .iImm3(iImm3),
        .bImm3(bImm3), .jImm3(jImm3),
        .opA(opA), .opB(opB), .rd4(rd4), .we4(we4), .aluFn4(aluFn4), .fn4(fn4),
        .pcSel4(pcSel4), .pc4(pc4), .bImm4(bImm4), .jImm4(jImm4)
    );

    executeStage i_execute (
        .clk(clk), .nrst(nrst), .opA(opA), .opB(opB), .rd4(rd4), .we4(we4),
        .aluFn4(aluFn4), .fn4(fn4), .pcSel4(pcSel4), .pc4(pc4), .bImm4(bImm4),
        .jImm4(jImm4), .branchTaken(branchTaken), .branchTarget(branchTarget),
        .aluRes5(aluRes5), .link5(link5), .rd5(rd5), .we5(we5), .pcSel5(pcSel5)
    );

    commitStage i_commit (
        .clk(clk), .nrst(nrst), .aluRes5(aluRes5), .link5(link5), .rd5(rd5),
        .we5(we5), .pcSel5(pcSel5), .we6(we6), .rdAddr6(rdAddr6), .wb6(wb6),
        .retireValid(retireValid), .retireRd(retireRd), .retireData(retireData)
    );

endmodule

`default_nettype wire

// ==== tb_pipeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pipeTop;

    localparam logic [31:0] SEED = 32'hd64b_d6d2;
    localparam logic [31:0] POLY = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
    localparam int NUM_INSTR = 148;                 // 50 + 27 + 3 + 60 + 8
    localparam int CYCLE_LIMIT = NUM_INSTR * 3 + 50;  // reset, drain and margin
    // {alt, funct3} codes with entry k at bits 4k+3:4k
    localparam logic [39:0] R_OPS = {4'b0011, 4'b0010, 4'b1101, 4'b0101, 4'b0001,
                                     4'b0100, 4'b0110, 4'b0111, 4'b1000, 4'b0000};
    localparam logic [35:0] I_OPS = {4'b1101, 4'b0101, 4'b0001, 4'b0111, 4'b0110,
                                     4'b0100, 4'b0011, 4'b0010, 4'b0000};
    localparam logic [17:0] B_F3  = {3'b111, 3'b110, 3'b101, 3'b100, 3'b001, 3'b000};

    logic          clk = 1'b0;
    logic          nrst;
    logic          instrValid;
    rvPkg::instrU  instr;
    logic [31:0]   pc;
    logic          branchTaken;
    logic [31:0]   branchTarget;
    logic          retireValid;
    logic [4:0]    retireRd;
    logic [31:0]   retireData;

    logic [31:0]   lfsr;
    logic [31:0]   pcNow;
    logic [31:0]   shadow [0:31];       // reference register file
    // expected outputs per drive slot
    logic          expTaken [0:1023];
    logic [31:0]   expTarget [0:1023];
    logic          expRetire [0:1023];
    logic [4:0]    expRd [0:1023];
    logic [31:0]   expData [0:1023];
    logic          expChkData [0:1023];
    int            n;                   // slots driven so far
    int            cycles;
    int            errors;
    int            checks;
    int            errMark;

    pipeTop i_dut (
        .clk(clk), .nrst(nrst), .instrValid(instrValid), .instr(instr), .pc(pc),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .retireValid(retireValid), .retireRd(retireRd), .retireData(retireData)
    );

    initial
    begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ POLY) : (s >> 1);
    endfunction

    task automatic takeBits(input int nBits, output logic [31:0] v);
        v = '0;
        repeat (nBits)
        begin
            v = {v[30:0], lfsr[0]};     // one lfsr step per bit
            lfsr = lfsrNext(lfsr);
        end
    endtask

    function automatic rvPkg::instrU encR(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        rvPkg::instrU w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = rvPkg::OP_OP;
        return w;
    endfunction

    function automatic rvPkg::instrU encI(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        rvPkg::instrU w;
        w.i.imm12  = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = op;
        return w;
    endfunction

    function automatic rvPkg::instrU encB(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        rvPkg::instrU w;
        w.b.imm12    = imm[12];
        w.b.imm10to5 = imm[10:5];
        w.b.rs2      = rs2;
        w.b.rs1      = rs1;
        w.b.funct3   = f3;
        w.b.imm4to1  = imm[4:1];
        w.b.imm11    = imm[11];
        w.b.opcode   = rvPkg::OP_BRANCH;
        return w;
    endfunction

    function automatic rvPkg::instrU encJ(input logic [20:0] imm, input logic [4:0] rd);
        rvPkg::instrU w;
        w.j.imm20     = imm[20];
        w.j.imm10to1  = imm[10:1];
        w.j.imm11     = imm[11];
        w.j.imm19to12 = imm[19:12];
        w.j.rd        = rd;
        w.j.opcode    = rvPkg::OP_JAL;
        return w;
    endfunction

    // rv32i arithmetic by {alt, funct3}
    function automatic logic [31:0] refAlu(input logic [3:0] op, input logic [31:0] a,
        input logic [31:0] b);
        case (op)
            4'b1000: return a - b;
            4'b0001: return a << b[4:0];
            4'b0010: return {31'd0, $signed(a) < $signed(b)};
            4'b0011: return {31'd0, a < b};
            4'b0100: return a ^ b;
            4'b0101: return a >> b[4:0];
            4'b1101: return $signed(a) >>> b[4:0];
            4'b0110: return a | b;
            4'b0111: return a & b;
            default: return a + b;
        endcase
    endfunction

    function automatic logic refCond(input logic [2:0] f3, input logic [31:0] a,
        input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("** Error: %s = %h, expected %h (slot %0d)", name, got, exp, n);
        errors++;
    endtask

    // outputs are settled at the falling edge
    task automatic checkOutputs();
        int s;
        s = n - 2;                      // slot now in pipe #4
        if (s >= 0)
        begin
            checks++;
            assert (branchTaken === expTaken[s])
                else mismatch("branchTaken", branchTaken, expTaken[s]);
            if (expTaken[s])
            begin
                checks++;
                assert (branchTarget === expTarget[s])
                    else mismatch("branchTarget", branchTarget, expTarget[s]);
            end
        end
        s = n - 4;                      // slot now in pipe #6
        if (s >= 0)
        begin
            checks++;
            assert (retireValid === expRetire[s])
                else mismatch("retireValid", retireValid, expRetire[s]);
            if (expRetire[s])
            begin
                checks++;
                assert (retireRd === expRd[s]) else mismatch("retireRd", retireRd, expRd[s]);
                if (expChkData[s])
                begin
                    checks++;
                    assert (retireData === expData[s])
                        else mismatch("retireData", retireData, expData[s]);
                end
            end
        end
    endtask

    task automatic step(input logic v, input rvPkg::instrU w, input logic tk,
        input logic [31:0] tgt, input logic rv, input logic [4:0] rd,
        input logic [31:0] data, input logic chk);
        @(negedge clk);
        checkOutputs();
        instrValid    = v;
        instr         = w;
        pc            = pcNow;
        expTaken[n]   = tk;
        expTarget[n]  = tgt;
        expRetire[n]  = rv;
        expRd[n]      = rd;
        expData[n]    = data;
        expChkData[n] = chk;
        n++;
        if (v)
            pcNow = pcNow + 32'd4;
    endtask

    task automatic bubble();
        step(1'b0, '0, 1'b0, '0, 1'b0, '0, '0, 1'b0);
    endtask

    // two bubbles after every instruction as there is no forwarding
    task automatic emit(input rvPkg::instrU w, input logic tk, input logic [31:0] tgt,
        input logic rv, input logic [4:0] rd, input logic [31:0] data, input logic chk);
        step(1'b1, w, tk, tgt, rv, rd, data, chk);
        bubble();
        bubble();
    endtask

    task automatic aluOp(input logic [3:0] op, input logic isImm, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
        logic [31:0]  b;
        logic [31:0]  res;
        rvPkg::instrU w;
        if (isImm)
        begin
            b = {{20{imm[11]}}, imm};   // shifts only look at b[4:0]
            w = encI(imm, rs1, op[2:0], rd, rvPkg::OP_IMM);
        end
        else
        begin
            b = shadow[rs2];
            w = encR({1'b0, op[3], 5'd0}, rs2, rs1, op[2:0], rd);
        end
        res = refAlu(op, shadow[rs1], b);
        if (rd != 5'd0)
            shadow[rd] = res;
        emit(w, 1'b0, '0, rd != 5'd0, rd, res, 1'b1);  // x0 writes do not retire
    endtask

    task automatic loadRegWith(input logic [4:0] rd, input logic [19:0] u, input logic [11:0] imm);
        rvPkg::instrU w;
        w = {u, rd, rvPkg::OP_LUI};
        shadow[rd] = {u, 12'd0};
        emit(w, 1'b0, '0, 1'b1, rd, {u, 12'd0}, 1'b1);
        aluOp(4'b0000, 1'b1, rd, rd, 5'd0, imm);        // addi
    endtask

    task automatic loadReg(input logic [4:0] rd);
        logic [31:0] u;
        logic [31:0] lo;
        takeBits(20, u);
        takeBits(12, lo);
        loadRegWith(rd, u[19:0], lo[11:0]);
    endtask

    task automatic branchOp(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] r;
        logic [31:0] off;
        takeBits(12, r);
        off = {{19{r[11]}}, r[11:0], 1'b0};
        emit(encB(off[12:0], rs2, rs1, f3), refCond(f3, shadow[rs1], shadow[rs2]),
             pcNow + off, 1'b1, 5'd0, '0, 1'b0);          // retires without a write
    endtask

    task automatic jalOp(input logic [4:0] rd);
        logic [31:0] r;
        logic [31:0] off;
        logic [31:0] link;
        takeBits(20, r);
        off  = {{11{r[19]}}, r[19:0], 1'b0};
        link = pcNow + 32'd4;
        if (rd != 5'd0)
            shadow[rd] = link;
        emit(encJ(off[20:0], rd), 1'b1, pcNow + off, 1'b1, rd, link, 1'b1);
    endtask

    task automatic jalrOp(input logic [4:0] rd, input logic [4:0] rs1);
        logic [31:0] r;
        logic [31:0] tgt;
        logic [31:0] link;
        takeBits(12, r);
        tgt  = (shadow[rs1] + {{20{r[11]}}, r[11:0]}) & ~32'd1;
        link = pcNow + 32'd4;
        if (rd != 5'd0)
            shadow[rd] = link;
        emit(encI(r[11:0], rs1, 3'b000, rd, rvPkg::OP_JALR), 1'b1, tgt, 1'b1, rd, link, 1'b1);
    endtask

    // drain the test's last instruction and print one summary line
    task automatic endTest(input string name);
        bubble();
        bubble();
        if (errors == errMark)
            $display("%s: passed", name);
        else
            $display("%s: %0d errors", name, errors - errMark);
        errMark = errors;
    endtask

    initial
    begin
        logic [31:0] u;
        logic [31:0] lo;
        logic [3:0]  op;
        nrst       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        lfsr       = SEED;
        pcNow      = 32'h0000_1000;
        n          = 0;
        cycles     = 0;
        errors     = 0;
        checks     = 0;
        errMark    = 0;
        for (int k = 0; k < 32; k++)
            shadow[k] = '0;

        repeat (10) bubble();           // outputs must stay low in reset
        nrst = 1'b1;
        repeat (4) bubble();
        endTest("reset state");

        for (int k = 0; k < 10; k++)
        begin
            loadReg(5'd1);
            loadReg(5'd2);
            aluOp(R_OPS[4*k +: 4], 1'b0, 5'd3, 5'd1, 5'd2, '0);
        end
        endTest("register-register ALU");

        for (int k = 0; k < 9; k++)
        begin
            op = I_OPS[4*k +: 4];
            loadReg(5'd1);
            takeBits(12, lo);
            if (op[1:0] == 2'b01)
                lo[11:0] = {1'b0, op[3], 5'd0, lo[4:0]};   // shift-imm layout
            aluOp(op, 1'b1, 5'd3, 5'd1, 5'd0, lo[11:0]);
        end
        endTest("operand-B selection");

        takeBits(12, lo);
        aluOp(4'b0000, 1'b1, 5'd0, 5'd1, 5'd0, lo[11:0]);   // addi x0
        aluOp(4'b0000, 1'b0, 5'd4, 5'd0, 5'd0, '0);         // add x4, x0, x0
        jalOp(5'd0);                                        // retires with rd 0
        endTest("register zero");

        for (int c = 0; c < 6; c++)
        begin
            for (int it = 0; it < 2; it++)
            begin
                if (it == 0)
                begin
                    takeBits(20, u);    // equal operands
                    takeBits(12, lo);
                    loadRegWith(5'd1, u[19:0], lo[11:0]);
                    loadRegWith(5'd2, u[19:0], lo[11:0]);
                end
                else
                begin
                    loadReg(5'd1);
                    loadReg(5'd2);
                end
                branchOp(B_F3[3*c +: 3], 5'd1, 5'd2);
            end
        end
        endTest("branches");

        for (int it = 0; it < 2; it++)
        begin
            jalOp(5'd5);
            loadReg(5'd1);
            jalrOp(5'd6, 5'd1);
        end
        endTest("jumps");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rvPkg.sv
regFile.sv
decodeStage.sv
issueStage.sv
executeStage.sv
commitStage.sv
pipeTop.sv
tb_pipeTop.sv

// ==== Bender.yml ====
package:
  name: rv_pipe

sources:
  - rvPkg.sv
  - regFile.sv
  - decodeStage.sv
  - issueStage.sv
  - executeStage.sv
  - commitStage.sv
  - pipeTop.sv
  - target: simulation
    files:
      - tb_pipeTop.sv
